//--- logic/tomasulo_pkg.sv
// Tomasulo architectural definitions
`default_nettype none

package tomasulo_pkg;

	// Datapath
	localparam int data_width = 32; // Operand and result width

	// Producer tags
	localparam int tag_width = 2; // Enough for three stations plus none
	localparam logic [tag_width-1:0] tag_none = 2'd0; // Operand already valid
	localparam logic [tag_width-1:0] add1_tag = 2'd1; // First add station
	localparam logic [tag_width-1:0] add2_tag = 2'd2; // Second add station
	localparam logic [tag_width-1:0] mul1_tag = 2'd3; // Multiply station

	// Station count, tags run 1..num_stations
	localparam int num_stations = 3;

	// Operations the stations understand
	typedef enum logic [1:0] {
		op_add = 2'd0, // Vj + Vk
		op_sub = 2'd1, // Vj - Vk
		op_mul = 2'd2 // Low word of Vj * Vk
	} opcode_e;

endpackage

`default_nettype wire

//--- logic/rs_ctrl_pkg.sv
// Reservation station control definitions
`default_nettype none

package rs_ctrl_pkg;

	// Station life cycle
	typedef enum logic [1:0] {
		st_idle = 2'd0, // Free for issue
		st_wait = 2'd1, // Snooping CDB for operands
		st_exec = 2'd2, // Functional unit running
		st_bcast = 2'd3 // Result held until granted
	} station_state_e;

	// Execution latencies in cycles
	localparam int lat_add = 2; // Adder
	localparam int lat_mul = 10; // Multiplier

	// Down-counter width, must hold the largest latency
	localparam int timer_width = 4;

endpackage

`default_nettype wire

//--- logic/station_ctrl.sv
// Reservation station sequencer
`timescale 1ns/1ps
`default_nettype none

module station_ctrl (
	input wire logic clk,
	input wire logic reset,
	input wire logic issue_hit, // Issue addressed to this station
	input wire logic operands_ready, // Both source tags clear
	input wire logic timer_done, // Functional unit finished
	input wire logic grant, // CDB slot won
	output rs_ctrl_pkg::station_state_e state,
	output logic start_timer, // Pulse on entering exec
	output logic load_result, // Pulse to register the result
	output logic result_ready, // Request for the CDB
	output logic busy // Station occupied
);

	rs_ctrl_pkg::station_state_e state_q;
	rs_ctrl_pkg::station_state_e state_d;

	// Next state
	always_comb begin
		state_d = state_q; // Hold by default
		unique case (state_q)
			rs_ctrl_pkg::st_idle: begin
				if (issue_hit) begin
					state_d = rs_ctrl_pkg::st_wait; // Operands latched this edge
				end
			end
			rs_ctrl_pkg::st_wait: begin
				if (operands_ready) begin
					state_d = rs_ctrl_pkg::st_exec; // Timer starts with it
				end
			end
			rs_ctrl_pkg::st_exec: begin
				if (timer_done) begin
					state_d = rs_ctrl_pkg::st_bcast; // Result captured now
				end
			end
			rs_ctrl_pkg::st_bcast: begin
				if (grant) begin
					state_d = rs_ctrl_pkg::st_idle; // Result went out on CDB
				end
			end
			default: state_d = rs_ctrl_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= rs_ctrl_pkg::st_idle;
		end else begin
			state_q <= state_d;
		end
	end

	// Outputs decoded from the current state
	assign state = state_q;
	assign start_timer = (state_q == rs_ctrl_pkg::st_wait) && operands_ready;
	assign load_result = (state_q == rs_ctrl_pkg::st_exec) && timer_done;
	assign result_ready = (state_q == rs_ctrl_pkg::st_bcast);
	assign busy = (state_q != rs_ctrl_pkg::st_idle); // Includes the grant cycle

endmodule

`default_nettype wire

//--- logic/exec_timer.sv
// Functional unit latency timer
`timescale 1ns/1ps
`default_nettype none

module exec_timer #(
	parameter int latency = rs_ctrl_pkg::lat_add // Cycles from start to done
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic start, // Load and begin counting
	output logic done // One-cycle pulse at zero
);

	logic [rs_ctrl_pkg::timer_width-1:0] count_q;
	logic active_q; // Counting in progress

	always_ff @(posedge clk) begin
		if (reset) begin
			count_q <= '0;
			active_q <= 1'b0;
		end else if (start) begin
			count_q <= rs_ctrl_pkg::timer_width'(latency);
			active_q <= 1'b1;
		end else if (active_q) begin
			if (count_q == '0) begin
				active_q <= 1'b0; // Done already seen, go quiet
			end else begin
				count_q <= count_q - 1'b1;
			end
		end
	end

	// Only once per start, active drops right after
	assign done = active_q && (count_q == '0);

endmodule

`default_nettype wire

//--- logic/operand_capture.sv
// Source operand register with CDB snoop
`timescale 1ns/1ps
`default_nettype none

module operand_capture (
	input wire logic clk,
	input wire logic reset,
	input wire logic load, // Issue into this station
	input wire logic [tomasulo_pkg::data_width-1:0] src_value, // Vj or Vk
	input wire logic [tomasulo_pkg::tag_width-1:0] src_tag, // Qj or Qk
	input wire logic cdb_valid,
	input wire logic [tomasulo_pkg::tag_width-1:0] cdb_tag,
	input wire logic [tomasulo_pkg::data_width-1:0] cdb_value,
	output logic [tomasulo_pkg::data_width-1:0] value,
	output logic ready // Tag clear, value usable
);

	logic [tomasulo_pkg::data_width-1:0] value_q;
	logic [tomasulo_pkg::tag_width-1:0] tag_q;
	logic issue_fwd; // Producer broadcasting in the issue cycle
	logic snoop_hit; // Producer broadcasting while waiting

	assign issue_fwd = cdb_valid && (src_tag != tomasulo_pkg::tag_none) && (cdb_tag == src_tag);
	assign snoop_hit = cdb_valid && (tag_q != tomasulo_pkg::tag_none) && (cdb_tag == tag_q);

	// Tag is control state
	always_ff @(posedge clk) begin
		if (reset) begin
			tag_q <= tomasulo_pkg::tag_none;
		end else if (load) begin
			tag_q <= issue_fwd ? tomasulo_pkg::tag_none : src_tag;
		end else if (snoop_hit) begin
			tag_q <= tomasulo_pkg::tag_none; // Producer delivered
		end
	end

	// Payload
	always_ff @(posedge clk) begin
		if (load) begin
			value_q <= issue_fwd ? cdb_value : src_value;
		end else if (snoop_hit) begin
			value_q <= cdb_value;
		end
	end

	assign value = value_q;
	assign ready = (tag_q == tomasulo_pkg::tag_none);

endmodule

`default_nettype wire

//--- logic/reservation_station.sv
// Reservation station with its functional unit
`timescale 1ns/1ps
`default_nettype none

module reservation_station #(
	parameter logic [tomasulo_pkg::tag_width-1:0] station_tag = tomasulo_pkg::add1_tag,
	parameter int latency = rs_ctrl_pkg::lat_add, // Functional unit cycles
	parameter bit is_mul = 1'b0 // Multiplier instead of adder
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic issue_valid,
	input wire logic [tomasulo_pkg::tag_width-1:0] issue_station, // Target station
	input wire tomasulo_pkg::opcode_e issue_op,
	input wire logic [tomasulo_pkg::data_width-1:0] issue_vj,
	input wire logic [tomasulo_pkg::data_width-1:0] issue_vk,
	input wire logic [tomasulo_pkg::tag_width-1:0] issue_qj,
	input wire logic [tomasulo_pkg::tag_width-1:0] issue_qk,
	input wire logic cdb_valid,
	input wire logic [tomasulo_pkg::tag_width-1:0] cdb_tag,
	input wire logic [tomasulo_pkg::data_width-1:0] cdb_value,
	input wire logic grant, // From CDB arbiter
	output logic busy,
	output logic result_ready, // Requesting the CDB
	output logic [tomasulo_pkg::data_width-1:0] result_value
);

	rs_ctrl_pkg::station_state_e state;
	tomasulo_pkg::opcode_e op_q; // Held opcode
	logic issue_hit;
	logic vj_ready, vk_ready;
	logic [tomasulo_pkg::data_width-1:0] vj_value, vk_value;
	logic start_timer, timer_done, load_result;
	logic [tomasulo_pkg::data_width-1:0] fu_result; // Functional unit output
	logic [tomasulo_pkg::data_width-1:0] result_q;

	// Only an idle station takes an issue
	assign issue_hit = issue_valid && (issue_station == station_tag) &&
		(state == rs_ctrl_pkg::st_idle);

	always_ff @(posedge clk) begin
		if (issue_hit) begin
			op_q <= issue_op;
		end
	end

	operand_capture u_vj (
		.clk(clk), .reset(reset), .load(issue_hit),
		.src_value(issue_vj), .src_tag(issue_qj),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
		.value(vj_value), .ready(vj_ready)
	);

	operand_capture u_vk (
		.clk(clk), .reset(reset), .load(issue_hit),
		.src_value(issue_vk), .src_tag(issue_qk),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
		.value(vk_value), .ready(vk_ready)
	);

	station_ctrl u_ctrl (
		.clk(clk), .reset(reset), .issue_hit(issue_hit),
		.operands_ready(vj_ready && vk_ready), .timer_done(timer_done), .grant(grant),
		.state(state), .start_timer(start_timer), .load_result(load_result),
		.result_ready(result_ready), .busy(busy)
	);

	exec_timer #(.latency(latency)) u_timer (
		.clk(clk), .reset(reset), .start(start_timer), .done(timer_done)
	);

	// Functional unit, settles while the timer runs
	generate
		if (is_mul) begin : g_mul
			assign fu_result = (op_q == tomasulo_pkg::op_mul) ? vj_value * vk_value : '0; // Low word
		end else begin : g_add
			always_comb begin
				unique case (op_q)
					tomasulo_pkg::op_sub: fu_result = vj_value - vk_value;
					default: fu_result = vj_value + vk_value; // op_add
				endcase
			end
		end
	endgenerate

	// Stays put while waiting for grant
	always_ff @(posedge clk) begin
		if (load_result) begin
			result_q <= fu_result;
		end
	end

	assign result_value = result_q;

endmodule

`default_nettype wire

//--- logic/cdb_arbiter.sv
// Common data bus arbiter
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
	input wire logic [tomasulo_pkg::num_stations-1:0] result_ready, // Index 0 is tag 1
	input wire logic [tomasulo_pkg::num_stations-1:0][tomasulo_pkg::data_width-1:0] result_value,
	output logic [tomasulo_pkg::num_stations-1:0] grant, // One-hot or zero
	output logic cdb_valid,
	output logic [tomasulo_pkg::tag_width-1:0] cdb_tag,
	output logic [tomasulo_pkg::data_width-1:0] cdb_value
);

	// Lowest tag wins, same cycle grant and bus
	always_comb begin
		logic found;
		found = 1'b0;
		grant = '0;
		cdb_tag = tomasulo_pkg::tag_none; // Idle bus carries no tag
		cdb_value = '0;
		for (int i = 0; i < tomasulo_pkg::num_stations; i++) begin
			if (result_ready[i] && !found) begin
				found = 1'b1;
				grant[i] = 1'b1;
				cdb_tag = tomasulo_pkg::tag_width'(i + 1); // Station index to tag
				cdb_value = result_value[i];
			end
		end
		cdb_valid = found;
	end

endmodule

`default_nettype wire

//--- logic/rs_top.sv
// Reservation stations and common data bus
`timescale 1ns/1ps
`default_nettype none

module rs_top (
	input wire logic clk,
	input wire logic reset,
	input wire logic issue_valid,
	input wire logic [tomasulo_pkg::tag_width-1:0] issue_station,
	input wire tomasulo_pkg::opcode_e issue_op,
	input wire logic [tomasulo_pkg::data_width-1:0] issue_vj,
	input wire logic [tomasulo_pkg::data_width-1:0] issue_vk,
	input wire logic [tomasulo_pkg::tag_width-1:0] issue_qj,
	input wire logic [tomasulo_pkg::tag_width-1:0] issue_qk,
	output logic [tomasulo_pkg::num_stations-1:0] busy, // Bit 0 is ADD1
	output logic cdb_valid,
	output logic [tomasulo_pkg::tag_width-1:0] cdb_tag,
	output logic [tomasulo_pkg::data_width-1:0] cdb_value
);

	logic [tomasulo_pkg::num_stations-1:0] result_ready;
	logic [tomasulo_pkg::num_stations-1:0][tomasulo_pkg::data_width-1:0] result_value;
	logic [tomasulo_pkg::num_stations-1:0] grant;

	reservation_station #(
		.station_tag(tomasulo_pkg::add1_tag), .latency(rs_ctrl_pkg::lat_add), .is_mul(1'b0)
	) u_add1 (
		.clk(clk), .reset(reset), .issue_valid(issue_valid), .issue_station(issue_station),
		.issue_op(issue_op), .issue_vj(issue_vj), .issue_vk(issue_vk),
		.issue_qj(issue_qj), .issue_qk(issue_qk),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value), .grant(grant[0]),
		.busy(busy[0]), .result_ready(result_ready[0]), .result_value(result_value[0])
	);

	reservation_station #(
		.station_tag(tomasulo_pkg::add2_tag), .latency(rs_ctrl_pkg::lat_add), .is_mul(1'b0)
	) u_add2 (
		.clk(clk), .reset(reset), .issue_valid(issue_valid), .issue_station(issue_station),
		.issue_op(issue_op), .issue_vj(issue_vj), .issue_vk(issue_vk),
		.issue_qj(issue_qj), .issue_qk(issue_qk),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value), .grant(grant[1]),
		.busy(busy[1]), .result_ready(result_ready[1]), .result_value(result_value[1])
	);

	reservation_station #(
		.station_tag(tomasulo_pkg::mul1_tag), .latency(rs_ctrl_pkg::lat_mul), .is_mul(1'b1)
	) u_mul1 (
		.clk(clk), .reset(reset), .issue_valid(issue_valid), .issue_station(issue_station),
		.issue_op(issue_op), .issue_vj(issue_vj), .issue_vk(issue_vk),
		.issue_qj(issue_qj), .issue_qk(issue_qk),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value), .grant(grant[2]),
		.busy(busy[2]), .result_ready(result_ready[2]), .result_value(result_value[2])
	);

	// Single result bus shared by all stations
	cdb_arbiter u_arb (
		.result_ready(result_ready),
		.result_value(result_value),
		.grant(grant),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.cdb_value(cdb_value)
	);

endmodule

`default_nettype wire

//--- test/rs_top_checker.sv
// Station and CDB protocol assertions
`timescale 1ns/1ps
`default_nettype none

module rs_top_checker (
	input wire logic clk,
	input wire logic reset,
	input wire logic issue_valid,
	input wire logic [tomasulo_pkg::tag_width-1:0] issue_station,
	input wire logic [tomasulo_pkg::num_stations-1:0] busy,
	input wire logic cdb_valid,
	input wire logic [tomasulo_pkg::tag_width-1:0] cdb_tag
);

	int failures = 0; // Assertion failure count, read at end of run

	// Tag zero means no producer, never a broadcaster
	cdb_tag_nonzero: assert property (@(posedge clk) disable iff (reset)
		cdb_valid |-> cdb_tag != tomasulo_pkg::tag_none)
	else begin
		failures++;
		$error("CDB valid with tag zero");
	end

	issue_to_free: assert property (@(posedge clk) disable iff (reset)
		issue_valid && issue_station != tomasulo_pkg::tag_none |-> !busy[issue_station - 2'd1])
	else begin
		failures++;
		$error("Issue targets a busy station");
	end

	// A station frees only in the cycle after its grant
	for (genvar i = 0; i < tomasulo_pkg::num_stations; i++) begin : g_busy
		busy_fall_after_bcast: assert property (@(posedge clk) disable iff (reset)
			$fell(busy[i]) |-> $past(cdb_valid && cdb_tag == tomasulo_pkg::tag_width'(i + 1)))
		else begin
			failures++;
			$error("Busy fell without a broadcast of its tag");
		end
	end

endmodule

bind rs_top rs_top_checker u_checker (
	.clk(clk), .reset(reset), .issue_valid(issue_valid), .issue_station(issue_station),
	.busy(busy), .cdb_valid(cdb_valid), .cdb_tag(cdb_tag)
);

`default_nettype wire

//--- test/rs_top_tb.sv
// Reservation station testbench
`timescale 1ns/1ps
`default_nettype none

module rs_top_tb;

	localparam int num_entries = 13;
	// Multiply latency plus slack for every entry
	localparam int timeout_cycles = num_entries * (rs_ctrl_pkg::lat_mul + 20);
	localparam logic [1:0] no_tag = tomasulo_pkg::tag_none;
	localparam logic [1:0] add1 = tomasulo_pkg::add1_tag;
	localparam logic [1:0] add2 = tomasulo_pkg::add2_tag;
	localparam logic [1:0] mul1 = tomasulo_pkg::mul1_tag;
	localparam int add_bcast = rs_ctrl_pkg::lat_add + 2; // Issue edge to CDB without contention
	localparam int mul_bcast = rs_ctrl_pkg::lat_mul + 2;

	typedef struct packed {
		logic [1:0] station;
		tomasulo_pkg::opcode_e op;
		logic [31:0] vj;
		logic [31:0] vk;
		logic [1:0] qj;
		logic [1:0] qk;
		logic wait_idle; // Drain every station first
		logic [1:0] sync_tag; // Issue while this tag is on the CDB
		int after; // Earlier broadcaster or -1
		int exp_lat; // Exact issue to CDB cycles or 0
		logic [31:0] exp_val;
	} entry_t;

	logic clk;
	logic reset;
	logic issue_valid;
	logic [1:0] issue_station;
	tomasulo_pkg::opcode_e issue_op;
	logic [31:0] issue_vj;
	logic [31:0] issue_vk;
	logic [1:0] issue_qj;
	logic [1:0] issue_qk;
	logic [2:0] busy;
	logic cdb_valid;
	logic [1:0] cdb_tag;
	logic [31:0] cdb_value;

	entry_t tbl [num_entries];
	int issue_cyc [num_entries];
	int bcast_cyc [num_entries];
	int producer [4]; // Last entry issued to each tag
	bit pend_valid [4];
	int pend_idx [4];
	int cycle = 0;
	int entry_count = 0;
	int mismatches = 0;
	int other_errors = 0;
	int total_errors;

	rs_top UUT (
		.clk(clk), .reset(reset), .issue_valid(issue_valid), .issue_station(issue_station),
		.issue_op(issue_op), .issue_vj(issue_vj), .issue_vk(issue_vk),
		.issue_qj(issue_qj), .issue_qk(issue_qk), .busy(busy),
		.cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value)
	);

	always #50 clk = ~clk;

	// Operand as the station sees it after forwarding
	function automatic logic [31:0] operand_value(logic [31:0] v, logic [1:0] q);
		logic [31:0] r;
		r = (q == no_tag) ? v : tbl[producer[q]].exp_val;
		return r;
	endfunction

	function automatic logic [31:0] expected_result(tomasulo_pkg::opcode_e op, logic [31:0] a,
		logic [31:0] b);
		logic [31:0] r;
		case (op)
			tomasulo_pkg::op_sub: r = a - b;
			tomasulo_pkg::op_mul: r = a * b; // Low word only
			default: r = a + b;
		endcase
		return r;
	endfunction

	task automatic add_entry(input logic [1:0] station, input tomasulo_pkg::opcode_e op,
		input logic [1:0] qj, input logic [1:0] qk, input logic wait_idle,
		input logic [1:0] sync_tag, input int after, input int exp_lat);
		entry_t e;
		e.station = station;
		e.op = op;
		e.vj = $urandom(); // Ignored by the DUT when tagged
		e.vk = $urandom();
		e.qj = qj;
		e.qk = qk;
		e.wait_idle = wait_idle;
		e.sync_tag = sync_tag;
		e.after = after;
		e.exp_lat = exp_lat;
		e.exp_val = expected_result(op, operand_value(e.vj, qj), operand_value(e.vk, qk));
		tbl[entry_count] = e;
		producer[station] = entry_count;
		entry_count++;
	endtask

	function automatic bit can_issue(int idx);
		bit ok;
		ok = 1'b1;
		if (busy[tbl[idx].station - 2'd1]) begin
			ok = 1'b0; // Target still occupied
		end else if (tbl[idx].wait_idle && busy != 3'b000) begin
			ok = 1'b0;
		end else if (tbl[idx].sync_tag != no_tag &&
			!(cdb_valid && cdb_tag == tbl[idx].sync_tag)) begin
			ok = 1'b0; // Producer not broadcasting yet
		end
		return ok;
	endfunction

	task automatic drive_issue(int idx);
		issue_valid = 1'b1;
		issue_station = tbl[idx].station;
		issue_op = tbl[idx].op;
		issue_vj = tbl[idx].vj;
		issue_vk = tbl[idx].vk;
		issue_qj = tbl[idx].qj;
		issue_qk = tbl[idx].qk;
		issue_cyc[idx] = cycle + 1; // Next rising edge takes it
		pend_idx[tbl[idx].station] = idx;
		pend_valid[tbl[idx].station] = 1'b1;
	endtask

	// Cycle count and run limit
	always @(posedge clk) begin
		cycle = cycle + 1;
		if (cycle > timeout_cycles) begin
			$display("Timeout: run did not finish within %0d cycles", timeout_cycles);
			$display("Errors: %0d mismatches, %0d other", mismatches, other_errors);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// Scoreboard sampled mid-cycle
	always @(negedge clk) begin
		int idx;
		if (!reset) begin
			for (int t = 1; t <= 3; t++) begin
				if (pend_valid[t] && cycle >= issue_cyc[pend_idx[t]] && !busy[t - 1]) begin
					$display("Station %0d went idle at %0t before broadcasting", t, $time);
					other_errors++;
				end
			end
			if (cdb_valid) begin
				if (!pend_valid[cdb_tag]) begin
					$display("Unexpected CDB broadcast with tag %0d at %0t", cdb_tag, $time);
					other_errors++;
				end else begin
					idx = pend_idx[cdb_tag]; // Entry owning this tag
					if (cdb_value !== tbl[idx].exp_val) begin
						$display("Mismatch at %0t: entry %0d value %h, expected %h", $time,
							idx, cdb_value, tbl[idx].exp_val);
						mismatches++;
					end
					if (tbl[idx].exp_lat != 0 &&
						cycle - issue_cyc[idx] != tbl[idx].exp_lat) begin
						$display("Mismatch at %0t: entry %0d latency %0d, expected %0d", $time,
							idx, cycle - issue_cyc[idx], tbl[idx].exp_lat);
						mismatches++;
					end
					if (tbl[idx].after >= 0 && bcast_cyc[tbl[idx].after] < 0) begin
						$display("Mismatch at %0t: entry %0d broadcast before entry %0d", $time,
							idx, tbl[idx].after);
						mismatches++;
					end
					bcast_cyc[idx] = cycle;
					pend_valid[cdb_tag] = 1'b0;
				end
			end
		end
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_station = no_tag;
		issue_op = tomasulo_pkg::op_add;
		issue_vj = '0;
		issue_vk = '0;
		issue_qj = no_tag;
		issue_qk = no_tag;
		void'($urandom(84799)); // Seeds this thread once
		for (int i = 0; i < num_entries; i++) begin
			bcast_cyc[i] = -1;
			issue_cyc[i] = 0;
		end
		for (int t = 0; t < 4; t++) begin
			pend_valid[t] = 1'b0;
			pend_idx[t] = 0;
			producer[t] = 0;
		end

		add_entry(add1, tomasulo_pkg::op_add, no_tag, no_tag, 1'b1, no_tag, -1, add_bcast);
		add_entry(add2, tomasulo_pkg::op_sub, no_tag, no_tag, 1'b0, no_tag, -1, add_bcast);
		add_entry(mul1, tomasulo_pkg::op_mul, no_tag, no_tag, 1'b1, no_tag, -1, mul_bcast);
		add_entry(mul1, tomasulo_pkg::op_mul, no_tag, no_tag, 1'b1, no_tag, -1, 0);
		add_entry(add1, tomasulo_pkg::op_add, mul1, no_tag, 1'b0, no_tag, 3, 0); // Needs product
		add_entry(mul1, tomasulo_pkg::op_mul, no_tag, no_tag, 1'b1, no_tag, -1, 0);
		add_entry(add1, tomasulo_pkg::op_add, mul1, no_tag, 1'b0, no_tag, 5, 0);
		add_entry(add2, tomasulo_pkg::op_sub, mul1, no_tag, 1'b0, no_tag, 6, 0); // Loses to ADD1
		add_entry(add1, tomasulo_pkg::op_add, no_tag, no_tag, 1'b1, no_tag, -1, 0);
		add_entry(add2, tomasulo_pkg::op_add, add1, no_tag, 1'b0, add1, -1, 0); // Issue-cycle fwd
		add_entry(mul1, tomasulo_pkg::op_mul, no_tag, add2, 1'b0, add2, -1, 0);
		add_entry(mul1, tomasulo_pkg::op_mul, no_tag, no_tag, 1'b1, no_tag, -1, 0);
		add_entry(add2, tomasulo_pkg::op_sub, no_tag, mul1, 1'b0, no_tag, 11, 0);

		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		repeat (2) begin
			@(negedge clk);
			if (busy !== 3'b000 || cdb_valid !== 1'b0) begin
				$display("Mismatch at %0t: after reset busy %b cdb_valid %b", $time, busy,
					cdb_valid);
				mismatches++;
			end
		end

		for (int i = 0; i < num_entries; i++) begin
			while (!can_issue(i)) begin
				@(negedge clk);
			end
			drive_issue(i);
			@(negedge clk);
			issue_valid = 1'b0;
		end
		while (busy != 3'b000) begin
			@(negedge clk);
		end
		@(negedge clk);

		for (int i = 0; i < num_entries; i++) begin
			if (bcast_cyc[i] < 0) begin
				$display("Entry %0d never appeared on the CDB", i);
				other_errors++;
			end
		end
		total_errors = mismatches + other_errors + UUT.u_checker.failures;
		$display("Errors: %0d mismatches, %0d other, %0d assertion", mismatches, other_errors,
			UUT.u_checker.failures);
		if (total_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tomasulo_rs.f
logic/tomasulo_pkg.sv
logic/rs_ctrl_pkg.sv
logic/station_ctrl.sv
logic/exec_timer.sv
logic/operand_capture.sv
logic/reservation_station.sv
logic/cdb_arbiter.sv
logic/rs_top.sv
test/rs_top_checker.sv
test/rs_top_tb.sv

//--- Makefile
# Verilator build and run for the reservation station testbench

VERILATOR ?= verilator
TOP ?= rs_top_tb
FILELIST ?= tomasulo_rs.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
RUN_ARGS ?= +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
